// ==== lsu_tests.txt ====
# L: imm addr base_valid base_tag base_data tag expected_data
# S: imm addr base_valid base_tag base_data data_valid data_tag data b_count
# C tag data bus broadcast, B b_commit, F failure, H n load_ready low for n cycles
# W wait for sw_empty, V load_valid must be low, X a load must be refused
L 1 10 1 0 00 1 00000000
S 1 20 1 0 00 1 0 11111111 1
L 1 20 1 0 00 2 11111111
B
W
L 1 20 1 0 00 3 11111111
S 1 34 1 0 00 1 0 cafef00d 0
W
L 0 04 0 5 00 4 cafef00d
V
C 5 00000030
S 1 40 1 0 00 0 7 00000000 0
L 1 40 1 0 00 6 12345678
V
C 7 12345678
S 1 44 1 0 00 0 9 00000000 0
L 1 48 1 0 00 8 00000000
V
C 9 00000099
S 1 50 1 0 00 1 0 aaaaaaaa 1
F
L 1 50 1 0 00 a 00000000
S 1 50 1 0 00 1 0 bbbbbbbb 1
B
W
L 1 50 1 0 00 b bbbbbbbb
H 0c
L 1 20 1 0 00 c 11111111
X
L 1 34 1 0 00 d cafef00d
L 1 40 1 0 00 e 12345678
W

// ==== sources.f ====
+incdir+.
lsu_pkg.sv
lsu_agu.sv
lsu_load_queue.sv
lsu_store_queue.sv
lsu_data_mem.sv
lsu_top.sv
tb_lsu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_lsu
OBJ_DIR ?= obj_dir
FILELIST ?= sources.f
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_lsu.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module tb_lsu;
	import lsu_pkg::*;

	localparam int HALF = 4;

	logic       clk = 1'b0;
	logic       reset = 1'b1;
	logic       issue_valid = 1'b0;
	logic       issue_ready;
	logic       issue_is_store = 1'b0;
	logic       issue_imm = 1'b0;
	mem_addr_t  issue_addr = '0;
	logic       issue_base_valid = 1'b0;
	rob_tag_t   issue_base_tag = '0;
	mem_addr_t  issue_base_data = '0;
	logic       issue_data_valid = 1'b0;
	rob_tag_t   issue_data_tag = '0;
	word_t      issue_data_data = '0;
	rob_tag_t   issue_tag = '0;
	b_count_t   issue_b_count = '0;
	logic       cdb_valid = 1'b0;
	rob_tag_t   cdb_tag = '0;
	word_t      cdb_data = '0;
	logic       b_commit = 1'b0;
	logic       failure = 1'b0;
	logic       load_valid;
	logic       load_ready = 1'b1;
	rob_tag_t   load_tag;
	word_t      load_data;
	logic       sw_empty;

	string      cmds [$];
	int         n_cmds = 0;
	int         n_fail = 0;
	rob_tag_t   exp_tag [$]; // loads in program order
	word_t      exp_data [$];
	logic       data_due = 1'b0;
	word_t      due_data;
	logic       held = 1'b0;
	rob_tag_t   held_tag;

	lsu_top dut (.*);

	always #HALF clk = ~clk;

	task automatic abort_run();
		n_fail++;
		$display("=== FAIL ===");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic issue_op(input logic st, input logic imm, input mem_addr_t addr,
			input logic bv, input rob_tag_t bt, input mem_addr_t bd, input logic dv,
			input rob_tag_t dt, input word_t dd, input rob_tag_t tag, input b_count_t bc);
		issue_is_store = st;
		issue_imm = imm;
		issue_addr = addr;
		issue_base_valid = bv;
		issue_base_tag = bt;
		issue_base_data = bd;
		issue_data_valid = dv;
		issue_data_tag = dt;
		issue_data_data = dd;
		issue_tag = tag;
		issue_b_count = bc;
		issue_valid = 1'b1;
		#1;
		while (!issue_ready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		issue_valid = 1'b0;
	endtask

	task automatic pulse_bus(input rob_tag_t tag, input word_t data);
		cdb_valid = 1'b1;
		cdb_tag = tag;
		cdb_data = data;
		@(negedge clk);
		cdb_valid = 1'b0;
	endtask

	task automatic hold_load_ready(input int n);
		fork
			begin
				load_ready = 1'b0;
				repeat (n) @(negedge clk);
				load_ready = 1'b1;
			end
		join_none
	endtask

	task automatic run_cmd(input string line);
		string word;
		int    n;
		int    v0, v1, v2, v3, v4, v5, v6, v7, v8;
		n = $sscanf(line, "%s", word);
		if (word == "L") begin
			n = $sscanf(line, "%s %h %h %h %h %h %h %h", word, v0, v1, v2, v3, v4, v5, v6);
			exp_tag.push_back(rob_tag_t'(v5));
			exp_data.push_back(word_t'(v6));
			issue_op(1'b0, v0[0], mem_addr_t'(v1), v2[0], rob_tag_t'(v3), mem_addr_t'(v4),
				1'b0, '0, '0, rob_tag_t'(v5), '0);
		end else if (word == "S") begin
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", word,
				v0, v1, v2, v3, v4, v5, v6, v7, v8);
			issue_op(1'b1, v0[0], mem_addr_t'(v1), v2[0], rob_tag_t'(v3), mem_addr_t'(v4),
				v5[0], rob_tag_t'(v6), word_t'(v7), '0, b_count_t'(v8));
			// an accepted store sits in the queue for at least one cycle
			assert (sw_empty == 1'b0) else begin
				$display("** Error: sw_empty = %h, expected %h", sw_empty, 1'b0);
				abort_run();
			end
		end else if (word == "C") begin
			n = $sscanf(line, "%s %h %h", word, v0, v1);
			pulse_bus(rob_tag_t'(v0), word_t'(v1));
		end else if (word == "B") begin
			b_commit = 1'b1;
			@(negedge clk);
			b_commit = 1'b0;
		end else if (word == "F") begin
			failure = 1'b1;
			@(negedge clk);
			failure = 1'b0;
		end else if (word == "H") begin
			n = $sscanf(line, "%s %h", word, v0);
			hold_load_ready(v0);
		end else if (word == "W") begin
			while (!sw_empty)
				@(negedge clk);
		end else if (word == "V") begin
			#1;
			assert (load_valid == 1'b0) else begin
				$display("** Error: load_valid = %h, expected %h", load_valid, 1'b0);
				abort_run();
			end
			@(negedge clk);
		end else if (word == "X") begin
			issue_is_store = 1'b0; // offer a load, valid stays low
			issue_imm = 1'b1;
			#1;
			assert (issue_ready == 1'b0) else begin
				$display("** Error: issue_ready = %h, expected %h", issue_ready, 1'b0);
				abort_run();
			end
			@(negedge clk);
		end else begin
			$display("unknown command in test file: %s", line);
			abort_run();
		end
	endtask

	// sampled just before the rising edge
	initial begin
		@(negedge reset);
		forever begin
			@(negedge clk);
			#(HALF - 1);
			if (data_due) begin
				assert (load_data == due_data) else begin
					$display("** Error: load_data = %h, expected %h", load_data, due_data);
					abort_run();
				end
				data_due = 1'b0;
			end
			if (held) begin
				assert (load_valid && load_tag == held_tag) else begin
					$display("** Error: load_valid/load_tag = %h/%h, expected %h/%h",
						load_valid, load_tag, 1'b1, held_tag);
					abort_run();
				end
			end
			if (load_valid && load_ready) begin
				if (exp_tag.size() == 0) begin
					$display("a load was delivered with no load outstanding");
					abort_run();
				end
				assert (load_tag == exp_tag[0]) else begin
					$display("** Error: load_tag = %h, expected %h", load_tag, exp_tag[0]);
					abort_run();
				end
				due_data = exp_data.pop_front();
				exp_tag.pop_front();
				data_due = 1'b1;
			end
			held = load_valid && !load_ready;
			held_tag = load_tag;
		end
	end

	initial begin
		wait (n_cmds > 0);
		#(n_cmds * 200 * 2 * HALF);
		$display("watchdog expired before the tests completed");
		$display("=== FAIL ===");
		$fatal(1, "timeout");
	end

	initial begin
		int    fd;
		int    n;
		string line;
		fd = $fopen("lsu_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open lsu_tests.txt");
			abort_run();
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 1 && line.substr(0, 0) != "#")
				cmds.push_back(line);
		end
		$fclose(fd);
		n_cmds = cmds.size();
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		foreach (cmds[i])
			run_cmd(cmds[i]);
		while (exp_tag.size() != 0 || data_due) // drain outstanding loads
			@(negedge clk);
		if (n_fail == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1, "errors seen");
		end
	end

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               issue_valid,
	output logic               issue_ready,
	input  logic               issue_is_store,
	input  logic               issue_imm,
	input  lsu_pkg::mem_addr_t issue_addr,
	input  logic               issue_base_valid,
	input  lsu_pkg::rob_tag_t  issue_base_tag,
	input  lsu_pkg::mem_addr_t issue_base_data,
	input  logic               issue_data_valid,
	input  lsu_pkg::rob_tag_t  issue_data_tag,
	input  lsu_pkg::word_t     issue_data_data,
	input  lsu_pkg::rob_tag_t  issue_tag,
	input  lsu_pkg::b_count_t  issue_b_count,
	input  logic               cdb_valid,
	input  lsu_pkg::rob_tag_t  cdb_tag,
	input  lsu_pkg::word_t     cdb_data,
	input  logic               b_commit,
	input  logic               failure,
	output logic               load_valid,
	input  logic               load_ready,
	output lsu_pkg::rob_tag_t  load_tag,
	output lsu_pkg::word_t     load_data,
	output logic               sw_empty
);
	import lsu_pkg::*;

	logic       accept;
	logic       agu_fire;
	logic       agu_full;
	mem_op_t    agu_kind;
	store_ptr_t agu_ptr;
	mem_addr_t  agu_addr;
	logic       load_pop;
	logic       load_full;
	store_ptr_t load_count;
	logic       store_commit;
	logic       store_full;
	store_ptr_t store_count;
	mem_addr_t  head_addr;
	word_t      head_data;
	logic [`LSU_N_STORE-1:0] sq_ready;
	mem_addr_t  sq_addr [`LSU_N_STORE];
	word_t      sq_data [`LSU_N_STORE];
	mem_addr_t  mem_raddr;
	word_t      mem_rdata;

	// a full queue still takes one if it frees a slot this cycle
	assign issue_ready = (issue_imm || !agu_full || agu_fire)
	                     && (issue_is_store || !load_full || load_pop)
	                     && (!issue_is_store || !store_full || store_commit);
	assign accept = issue_valid && issue_ready;

	lsu_agu u_agu (
		.clk, .reset, .accept, .issue_is_store, .issue_imm,
		.issue_base_valid, .issue_base_tag, .issue_base_data, .issue_addr,
		.load_ptr(load_count), .store_ptr(store_count), .load_pop, .store_commit,
		.cdb_valid, .cdb_tag, .cdb_data,
		.agu_fire, .agu_kind, .agu_ptr, .agu_addr, .agu_full
	);

	lsu_load_queue u_load_queue (
		.clk, .reset, .accept, .issue_is_store, .issue_imm, .issue_addr, .issue_tag,
		.store_count, .store_commit, .agu_fire, .agu_kind, .agu_ptr, .agu_addr,
		.sq_ready, .sq_addr, .sq_data, .mem_rdata, .mem_raddr,
		.load_ready, .load_valid, .load_pop, .load_full, .load_count, .load_tag, .load_data
	);

	lsu_store_queue u_store_queue (
		.clk, .reset, .accept, .issue_is_store, .issue_imm, .issue_addr,
		.issue_data_valid, .issue_data_tag, .issue_data_data, .issue_b_count,
		.cdb_valid, .cdb_tag, .cdb_data, .agu_fire, .agu_kind, .agu_ptr, .agu_addr,
		.b_commit, .failure, .store_commit, .head_addr, .head_data, .store_count,
		.sq_ready, .sq_addr, .sq_data, .store_full, .sw_empty
	);

	lsu_data_mem u_data_mem (
		.clk,
		.we(store_commit), // head store written on the commit edge
		.waddr(head_addr),
		.raddr(mem_raddr),
		.wdata(head_data),
		.rdata(mem_rdata)
	);

endmodule

// ==== lsu_data_mem.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_data_mem (
	input  logic               clk,
	input  logic               we,
	input  lsu_pkg::mem_addr_t waddr,
	input  lsu_pkg::mem_addr_t raddr,
	input  lsu_pkg::word_t     wdata,
	output lsu_pkg::word_t     rdata
);
	import lsu_pkg::*;

	word_t mem [2**`LSU_ADDR_WIDTH]; // distributed RAM

	initial begin
		for (int i = 0; i < 2**`LSU_ADDR_WIDTH; i++)
			mem[i] = '0;
	end

	always @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	assign rdata = mem[raddr]; // async read

endmodule

// ==== lsu_store_queue.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_store_queue (
	input  logic                clk,
	input  logic                reset,
	input  logic                accept,
	input  logic                issue_is_store,
	input  logic                issue_imm,
	input  lsu_pkg::mem_addr_t  issue_addr,
	input  logic                issue_data_valid,
	input  lsu_pkg::rob_tag_t   issue_data_tag,
	input  lsu_pkg::word_t      issue_data_data,
	input  lsu_pkg::b_count_t   issue_b_count,
	input  logic                cdb_valid,
	input  lsu_pkg::rob_tag_t   cdb_tag,
	input  lsu_pkg::word_t      cdb_data,
	input  logic                agu_fire,
	input  lsu_pkg::mem_op_t    agu_kind,
	input  lsu_pkg::store_ptr_t agu_ptr,
	input  lsu_pkg::mem_addr_t  agu_addr,
	input  logic                b_commit,
	input  logic                failure,
	output logic                store_commit,
	output lsu_pkg::mem_addr_t  head_addr,
	output lsu_pkg::word_t      head_data,
	output lsu_pkg::store_ptr_t store_count,
	output logic [`LSU_N_STORE-1:0] sq_ready,
	output lsu_pkg::mem_addr_t  sq_addr [`LSU_N_STORE],
	output lsu_pkg::word_t      sq_data [`LSU_N_STORE],
	output logic                store_full,
	output logic                sw_empty
);
	import lsu_pkg::*;

	localparam int N = `LSU_N_STORE;

	logic       addr_valid [N];
	logic       data_valid [N];
	rob_tag_t   data_tag [N];
	b_count_t   b_count [N];

	logic       acc;
	logic       new_dv;
	store_ptr_t n_keep;
	logic       agu_hit [N];
	logic       cdb_hit [N];
	b_count_t   upd_b [N];

	assign acc = accept && issue_is_store && !failure; // wrong-path store never enters
	assign new_dv = issue_data_valid || (cdb_valid && cdb_tag == issue_data_tag);

	always_comb begin
		n_keep = '0;
		for (int j = 0; j < N; j++) begin
			agu_hit[j] = agu_fire && agu_kind == op_store && agu_ptr == store_ptr_t'(j);
			cdb_hit[j] = !data_valid[j] && cdb_valid && cdb_tag == data_tag[j];
			upd_b[j] = (b_count[j] == '0) ? '0 : b_count[j] - b_count_t'(b_commit);
			sq_ready[j] = addr_valid[j] && data_valid[j];
			// non-speculative entries form a prefix
			if (store_ptr_t'(j) < store_count && b_count[j] == '0)
				n_keep = n_keep + 1'b1;
		end
	end

	assign store_commit = store_count != '0 && b_count[0] == '0 && sq_ready[0];
	assign head_addr = sq_addr[0];
	assign head_data = sq_data[0];
	assign store_full = int'(store_count) == N;
	assign sw_empty = store_count == '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			store_count <= '0;
		end else if (failure) begin
			store_count <= n_keep - store_ptr_t'(store_commit);
		end else begin
			store_count <= store_count - store_ptr_t'(store_commit) + store_ptr_t'(acc);
		end
		for (int j = 0; j < N; j++) begin
			if (j + int'(store_commit) < int'(store_count)) begin
				addr_valid[j] <= addr_valid[j + int'(store_commit)]
				                 || agu_hit[j + int'(store_commit)];
				sq_addr[j]    <= agu_hit[j + int'(store_commit)] ? agu_addr
				                                                 : sq_addr[j + int'(store_commit)];
				data_valid[j] <= data_valid[j + int'(store_commit)]
				                 || cdb_hit[j + int'(store_commit)];
				sq_data[j]    <= cdb_hit[j + int'(store_commit)] ? cdb_data
				                                                 : sq_data[j + int'(store_commit)];
				data_tag[j]   <= data_tag[j + int'(store_commit)];
				b_count[j]    <= upd_b[j + int'(store_commit)];
			end else begin
				addr_valid[j] <= issue_imm;
				sq_addr[j]    <= issue_addr;
				data_valid[j] <= new_dv;
				sq_data[j]    <= issue_data_valid ? issue_data_data : cdb_data;
				data_tag[j]   <= issue_data_tag;
				b_count[j]    <= issue_b_count;
			end
		end
	end

	// relies on the top blocking stores while full
	assert property (@(posedge clk) disable iff (reset) int'(store_count) <= N);

endmodule

// ==== lsu_load_queue.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_load_queue (
	input  logic                clk,
	input  logic                reset,
	input  logic                accept,
	input  logic                issue_is_store,
	input  logic                issue_imm,
	input  lsu_pkg::mem_addr_t  issue_addr,
	input  lsu_pkg::rob_tag_t   issue_tag,
	input  lsu_pkg::store_ptr_t store_count,
	input  logic                store_commit,
	input  logic                agu_fire,
	input  lsu_pkg::mem_op_t    agu_kind,
	input  lsu_pkg::store_ptr_t agu_ptr,
	input  lsu_pkg::mem_addr_t  agu_addr,
	input  logic [`LSU_N_STORE-1:0] sq_ready,
	input  lsu_pkg::mem_addr_t  sq_addr [`LSU_N_STORE],
	input  lsu_pkg::word_t      sq_data [`LSU_N_STORE],
	input  lsu_pkg::word_t      mem_rdata,
	output lsu_pkg::mem_addr_t  mem_raddr,
	input  logic                load_ready,
	output logic                load_valid,
	output logic                load_pop,
	output logic                load_full,
	output lsu_pkg::store_ptr_t load_count,
	output lsu_pkg::rob_tag_t   load_tag,
	output lsu_pkg::word_t      load_data
);
	import lsu_pkg::*;

	localparam int N = `LSU_N_LOAD;

	rob_tag_t   tag [N];
	logic       addr_valid [N];
	mem_addr_t  addr [N];
	store_ptr_t older [N]; // stores still ahead of this load

	logic       acc;
	logic       disamb;
	word_t      fwd_data;
	logic       upd_av [N];
	mem_addr_t  upd_addr [N];
	store_ptr_t upd_older [N];

	assign acc = accept && !issue_is_store;

	always_comb begin
		for (int j = 0; j < N; j++) begin
			if (agu_fire && agu_kind == op_load && agu_ptr == store_ptr_t'(j)) begin
				upd_av[j] = 1'b1;
				upd_addr[j] = agu_addr;
			end else begin
				upd_av[j] = addr_valid[j];
				upd_addr[j] = addr[j];
			end
			upd_older[j] = (older[j] == '0) ? '0 : older[j] - store_ptr_t'(store_commit);
		end
	end

	// all older stores need address and data before the head may go
	always_comb begin
		disamb = 1'b1;
		fwd_data = mem_rdata;
		for (int j = 0; j < `LSU_N_STORE; j++) begin
			if (store_ptr_t'(j) < older[0]) begin
				if (!sq_ready[j])
					disamb = 1'b0;
				if (sq_addr[j] == addr[0])
					fwd_data = sq_data[j]; // later hit is younger
			end
		end
	end

	assign load_valid = load_count != '0 && addr_valid[0] && disamb;
	assign load_pop = load_valid && load_ready;
	assign load_tag = tag[0];
	assign load_full = int'(load_count) == N;
	assign mem_raddr = addr[0];

	always_ff @(posedge clk) begin
		if (reset) begin
			load_count <= '0;
		end else begin
			load_count <= load_count - store_ptr_t'(load_pop) + store_ptr_t'(acc);
		end
		for (int j = 0; j < N; j++) begin
			if (j + int'(load_pop) < int'(load_count)) begin
				tag[j]        <= tag[j + int'(load_pop)];
				addr_valid[j] <= upd_av[j + int'(load_pop)];
				addr[j]       <= upd_addr[j + int'(load_pop)];
				older[j]      <= upd_older[j + int'(load_pop)];
			end else begin
				tag[j]        <= issue_tag;
				addr_valid[j] <= issue_imm;
				addr[j]       <= issue_addr;
				older[j]      <= store_count - store_ptr_t'(store_commit);
			end
		end
		if (load_pop)
			load_data <= fwd_data;
	end

endmodule

// ==== lsu_agu.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_agu (
	input  logic                clk,
	input  logic                reset,
	input  logic                accept,
	input  logic                issue_is_store,
	input  logic                issue_imm,
	input  logic                issue_base_valid,
	input  lsu_pkg::rob_tag_t   issue_base_tag,
	input  lsu_pkg::mem_addr_t  issue_base_data,
	input  lsu_pkg::mem_addr_t  issue_addr,
	input  lsu_pkg::store_ptr_t load_ptr,
	input  lsu_pkg::store_ptr_t store_ptr,
	input  logic                load_pop,
	input  logic                store_commit,
	input  logic                cdb_valid,
	input  lsu_pkg::rob_tag_t   cdb_tag,
	input  lsu_pkg::word_t      cdb_data,
	output logic                agu_fire,
	output lsu_pkg::mem_op_t    agu_kind,
	output lsu_pkg::store_ptr_t agu_ptr,
	output lsu_pkg::mem_addr_t  agu_addr,
	output logic                agu_full
);
	import lsu_pkg::*;

	localparam int N = `LSU_N_AGU;
	localparam int CNT_W = $clog2(N + 1);

	logic [CNT_W-1:0] count;
	mem_op_t          kind [N];
	store_ptr_t       ptr [N]; // position in the target queue
	logic             base_valid [N];
	rob_tag_t         base_tag [N];
	mem_addr_t        base [N];
	mem_addr_t        offset [N];

	logic             acc;
	mem_addr_t        cdb_base;
	logic             cdb_hit [N];
	store_ptr_t       upd_ptr [N];
	int               sel;
	int               src [N];

	assign acc = accept && !issue_imm;
	assign cdb_base = cdb_data[`LSU_ADDR_WIDTH-1:0];

	always_comb begin
		for (int j = 0; j < N; j++) begin
			cdb_hit[j] = !base_valid[j] && cdb_valid && cdb_tag == base_tag[j];
			// follow the target queue as it shifts down
			upd_ptr[j] = (kind[j] == op_load) ? ptr[j] - store_ptr_t'(load_pop)
			                                  : ptr[j] - store_ptr_t'(store_commit);
		end
	end

	// oldest entry whose base is known
	always_comb begin
		agu_fire = 1'b0;
		sel = 0;
		for (int j = N - 1; j >= 0; j--) begin
			if (j < int'(count) && base_valid[j]) begin
				agu_fire = 1'b1;
				sel = j;
			end
		end
		for (int j = 0; j < N; j++) begin
			src[j] = (agu_fire && j >= sel) ? j + 1 : j; // close the gap of the fired one
		end
	end

	assign agu_kind = kind[sel];
	assign agu_ptr = ptr[sel];
	assign agu_addr = base[sel] + offset[sel];
	assign agu_full = int'(count) == N;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count - CNT_W'(agu_fire) + CNT_W'(acc);
		end
		for (int j = 0; j < N; j++) begin
			if (src[j] < int'(count)) begin
				kind[j]       <= kind[src[j]];
				ptr[j]        <= upd_ptr[src[j]];
				base_valid[j] <= base_valid[src[j]] || cdb_hit[src[j]];
				base_tag[j]   <= base_tag[src[j]];
				base[j]       <= cdb_hit[src[j]] ? cdb_base : base[src[j]];
				offset[j]     <= offset[src[j]];
			end else begin
				kind[j]       <= issue_is_store ? op_store : op_load;
				ptr[j]        <= issue_is_store ? store_ptr - store_ptr_t'(store_commit)
				                                : load_ptr - store_ptr_t'(load_pop);
				base_valid[j] <= issue_base_valid || (cdb_valid && cdb_tag == issue_base_tag);
				base_tag[j]   <= issue_base_tag;
				base[j]       <= issue_base_valid ? issue_base_data : cdb_base;
				offset[j]     <= issue_addr;
			end
		end
	end

	// issue logic in the top must hold back when no slot frees
	assert property (@(posedge clk) disable iff (reset) acc |-> !agu_full || agu_fire);

endmodule

// ==== lsu_pkg.sv ====
`include "lsu_params.svh"

package lsu_pkg;

	// result tag on the common data bus
	typedef logic [`LSU_ROB_WIDTH-1:0] rob_tag_t;

	// data memory word address
	typedef logic [`LSU_ADDR_WIDTH-1:0] mem_addr_t;

	typedef logic [31:0] word_t;

	// older unresolved branches, 0 .. N_BRANCH
	typedef logic [$clog2(`LSU_N_BRANCH):0] b_count_t;

	// store queue position or fill count, 0 .. N_STORE
	typedef logic [$clog2(`LSU_N_STORE):0] store_ptr_t;

	typedef enum logic {
		op_load,
		op_store
	} mem_op_t;

endpackage

// ==== lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// tag and address widths
`define LSU_ROB_WIDTH 4
`define LSU_ADDR_WIDTH 8

// queue depths
`define LSU_N_AGU 2
`define LSU_N_LOAD 2
`define LSU_N_STORE 4

// unresolved branches the core can have in flight
`define LSU_N_BRANCH 4

`endif
